/* exe_defs.svh */
`ifndef EXE_DEFS_SVH
`define EXE_DEFS_SVH

//////////////////////////////
// Data path widths
`define WORD_W      32
`define DWORD_W     (2*`WORD_W)
`define REG_ADDR_W  5
`define SHAMT_W     5

// Leading-bit count needs to hold 0..32
`define CNT_W       6

//////////////////////////////
// Control fields carried down the pipe
`define OP_W        5
`define SEL_W       3
`define TRAP_W      3
`define HILO_WR_W   2

`endif

/* exe_ops_pkg.sv */
`include "exe_defs.svh"

package exe_ops_pkg;

    //////////////////////////////
    // Operation codes
    typedef enum logic [`OP_W-1:0] {
        OP_OR,   OP_AND,  OP_NOR,  OP_XOR,
        OP_SLL,  OP_SRL,  OP_SRA,
        OP_ADD,  OP_ADDU, OP_SUB,  OP_SUBU,
        OP_SLT,  OP_SLTU,
        OP_CLZ,  OP_CLO,
        OP_MULT, OP_MULTU, OP_MUL,
        OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
        OP_MOVZ, OP_MOVN,
        OP_TEQ,  OP_TNE,  OP_TGE,  OP_TGEU,
        OP_TLT,  OP_TLTU
    } exe_op_t;

    // Which unit feeds the write-back word
    typedef enum logic [`SEL_W-1:0] {
        SEL_LOGIC,
        SEL_SHIFT,
        SEL_ARITH,
        SEL_COUNT,
        SEL_MUL,
        SEL_MOVE,
        SEL_HILO,
        SEL_NONE
    } res_sel_t;

    // Trap condition on src1 vs src2
    typedef enum logic [`TRAP_W-1:0] {
        TRAP_NONE,
        TRAP_EQ,
        TRAP_NE,
        TRAP_GE,
        TRAP_LT
    } trap_kind_t;

    typedef enum logic [`HILO_WR_W-1:0] {
        HILO_NONE,
        HILO_PRODUCT,
        HILO_HI,
        HILO_LO
    } hilo_wr_t;

endpackage

/* exe_data_pkg.sv */
`include "exe_defs.svh"

package exe_data_pkg;

    //////////////////////////////
    // Data path types

    // One register word
    typedef logic [`WORD_W-1:0]     word_t;

    // Full product, also the HI/LO pair
    typedef logic [`DWORD_W-1:0]    dword_t;

    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Taken from the low bits of src1
    typedef logic [`SHAMT_W-1:0]    shamt_t;

    // CLZ / CLO result
    typedef logic [`CNT_W-1:0]      cnt_t;

endpackage

/* exe_decode.sv */
`timescale 1ns/100ps

module exe_decode import exe_ops_pkg::*, exe_data_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       valid_i,
    output logic       ready_o,
    input  exe_op_t    op_i,
    input  word_t      src1_i,
    input  word_t      src2_i,
    input  reg_addr_t  wd_i,
    input  logic       wreg_i,
    output logic       valid_o,
    input  logic       ready_i,
    output word_t      src1_o,
    output word_t      src2_o,
    output reg_addr_t  wd_o,
    output logic       wreg_o,
    output exe_op_t    op_o,
    output res_sel_t   sel_o,
    output logic       sub_o,
    output logic       signed_o,
    output logic       chk_ov_o,
    output trap_kind_t trap_o,
    output hilo_wr_t   hilo_wr_o
);

    logic       valid_q;
    logic       load;
    res_sel_t   sel_d;
    logic       sub_d;
    logic       signed_d;
    logic       chk_ov_d;
    trap_kind_t trap_d;
    hilo_wr_t   hilo_wr_d;

    assign ready_o = !valid_q || ready_i;
    assign load    = valid_i && ready_o;
    assign valid_o = valid_q;

    //////////////////////////////
    // Control flags

    // Compares go through the adder as a subtract
    assign sub_d = op_i inside {OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
                                OP_TGE, OP_TGEU, OP_TLT, OP_TLTU};
    assign signed_d = op_i inside {OP_SLT, OP_TGE, OP_TLT, OP_MULT, OP_MUL};
    assign chk_ov_d = op_i inside {OP_ADD, OP_SUB};

    always_comb begin
        sel_d     = SEL_NONE;
        trap_d    = TRAP_NONE;
        hilo_wr_d = HILO_NONE;
        case (op_i)
            OP_OR, OP_AND, OP_NOR, OP_XOR: sel_d = SEL_LOGIC;
            OP_SLL, OP_SRL, OP_SRA:        sel_d = SEL_SHIFT;
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
            OP_SLT, OP_SLTU:               sel_d = SEL_ARITH;
            OP_CLZ, OP_CLO:                sel_d = SEL_COUNT;
            OP_MUL:                        sel_d = SEL_MUL;
            OP_MULT, OP_MULTU: begin
                sel_d     = SEL_MUL;
                hilo_wr_d = HILO_PRODUCT;
            end
            OP_MFHI, OP_MFLO:              sel_d = SEL_HILO;
            OP_MTHI:                       hilo_wr_d = HILO_HI;
            OP_MTLO:                       hilo_wr_d = HILO_LO;
            OP_MOVZ, OP_MOVN:              sel_d = SEL_MOVE;
            OP_TEQ:                        trap_d = TRAP_EQ;
            OP_TNE:                        trap_d = TRAP_NE;
            OP_TGE, OP_TGEU:               trap_d = TRAP_GE;
            OP_TLT, OP_TLTU:               trap_d = TRAP_LT;
            default:                       sel_d = SEL_NONE;
        endcase
    end

    //////////////////////////////
    // Stage register
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            src1_o    <= src1_i;
            src2_o    <= src2_i;
            wd_o      <= wd_i;
            wreg_o    <= wreg_i;
            op_o      <= op_i;
            sel_o     <= sel_d;
            sub_o     <= sub_d;
            signed_o  <= signed_d;
            chk_ov_o  <= chk_ov_d;
            trap_o    <= trap_d;
            hilo_wr_o <= hilo_wr_d;
        end
    end

    // Stalled item at the input stays put until decode takes it
    a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i && !ready_o |=> valid_i && $stable({op_i, src1_i, src2_i, wd_i, wreg_i}));

endmodule

/* exe_alu.sv */
`timescale 1ns/100ps
`include "exe_defs.svh"

module exe_alu import exe_ops_pkg::*, exe_data_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       valid_i,
    output logic       ready_o,
    input  word_t      src1_i,
    input  word_t      src2_i,
    input  reg_addr_t  wd_i,
    input  logic       wreg_i,
    input  exe_op_t    op_i,
    input  res_sel_t   sel_i,
    input  logic       sub_i,
    input  logic       signed_i,
    input  logic       chk_ov_i,
    input  trap_kind_t trap_i,
    input  hilo_wr_t   hilo_wr_i,
    output logic       valid_o,
    input  logic       ready_i,
    output word_t      src1_o,
    output word_t      src2_o,
    output reg_addr_t  wd_o,
    output logic       wreg_o,
    output exe_op_t    op_o,
    output res_sel_t   sel_o,
    output trap_kind_t trap_o,
    output hilo_wr_t   hilo_wr_o,
    output word_t      logic_o,
    output word_t      shift_o,
    output word_t      arith_o,
    output cnt_t       count_o,
    output dword_t     prod_o,
    output logic       ov_o,
    output logic       lt_o,
    output logic       eq_o
);

    logic              valid_q;
    logic              load;
    word_t             logic_d;
    word_t             shift_d;
    shamt_t            shamt;
    word_t             add_b;
    word_t             sum;
    logic              carry;
    logic              ov_sum;
    logic              lt;
    logic              eq;
    word_t             arith_d;
    word_t             cnt_src;
    cnt_t              lead_cnt;
    dword_t            mul_a;
    dword_t            mul_b;
    dword_t            prod_d;

    assign ready_o = !valid_q || ready_i;
    assign load    = valid_i && ready_o;
    assign valid_o = valid_q;

    //////////////////////////////
    // Logic and shift
    always_comb begin
        case (op_i)
            OP_OR:   logic_d = src1_i | src2_i;
            OP_AND:  logic_d = src1_i & src2_i;
            OP_NOR:  logic_d = ~(src1_i | src2_i);
            OP_XOR:  logic_d = src1_i ^ src2_i;
            default: logic_d = '0;
        endcase
    end

    assign shamt = shamt_t'(src1_i[`SHAMT_W-1:0]);

    always_comb begin
        case (op_i)
            OP_SLL:  shift_d = src2_i << shamt;
            OP_SRL:  shift_d = src2_i >> shamt;
            OP_SRA:  shift_d = word_t'($signed(src2_i) >>> shamt);
            default: shift_d = '0;
        endcase
    end

    //////////////////////////////
    // Adder and compare
    assign add_b = sub_i ? ~src2_i : src2_i;
    assign {carry, sum} = {1'b0, src1_i} + {1'b0, add_b} + {{`WORD_W{1'b0}}, sub_i};

    // Same-sign operands giving an opposite-sign sum
    assign ov_sum = (src1_i[`WORD_W-1] == add_b[`WORD_W-1]) &&
                    (sum[`WORD_W-1] != src1_i[`WORD_W-1]);

    // No borrow out means src1 >= src2 unsigned
    assign lt = signed_i ? (sum[`WORD_W-1] ^ ov_sum) : !carry;
    assign eq = (src1_i == src2_i);

    assign arith_d = (op_i inside {OP_SLT, OP_SLTU}) ? {{(`WORD_W-1){1'b0}}, lt} : sum;

    //////////////////////////////
    // Leading zeros / ones
    assign cnt_src = (op_i == OP_CLO) ? ~src1_i : src1_i;

    always_comb begin
        lead_cnt = cnt_t'(`WORD_W);
        for (int i = 0; i < `WORD_W; i++) begin
            // Highest set bit wins
            if (cnt_src[i]) begin
                lead_cnt = cnt_t'(`WORD_W - 1 - i);
            end
        end
    end

    // Sign-extend to full width, low half of the wide product is exact
    assign mul_a  = {{`WORD_W{signed_i & src1_i[`WORD_W-1]}}, src1_i};
    assign mul_b  = {{`WORD_W{signed_i & src2_i[`WORD_W-1]}}, src2_i};
    assign prod_d = mul_a * mul_b;

    //////////////////////////////
    // Stage register
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            src1_o    <= src1_i;
            src2_o    <= src2_i;
            wd_o      <= wd_i;
            wreg_o    <= wreg_i;
            op_o      <= op_i;
            sel_o     <= sel_i;
            trap_o    <= trap_i;
            hilo_wr_o <= hilo_wr_i;
            logic_o   <= (sel_i == SEL_LOGIC) ? logic_d : '0;
            shift_o   <= (sel_i == SEL_SHIFT) ? shift_d : '0;
            arith_o   <= (sel_i == SEL_ARITH) ? arith_d : '0;
            count_o   <= (sel_i == SEL_COUNT) ? lead_cnt : '0;
            prod_o    <= (sel_i == SEL_MUL) ? prod_d : '0;
            ov_o      <= ov_sum & chk_ov_i;
            lt_o      <= lt;
            eq_o      <= eq;
        end
    end

    // Overflow is only ever flagged on an adder result
    a_ov_arith: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_q && ov_o |-> sel_o == SEL_ARITH);

endmodule

/* exe_result.sv */
`timescale 1ns/100ps
`include "exe_defs.svh"

module exe_result import exe_ops_pkg::*, exe_data_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       valid_i,
    output logic       ready_o,
    input  word_t      src1_i,
    input  word_t      src2_i,
    input  reg_addr_t  wd_i,
    input  logic       wreg_i,
    input  exe_op_t    op_i,
    input  res_sel_t   sel_i,
    input  trap_kind_t trap_i,
    input  hilo_wr_t   hilo_wr_i,
    input  word_t      logic_i,
    input  word_t      shift_i,
    input  word_t      arith_i,
    input  cnt_t       count_i,
    input  dword_t     prod_i,
    input  logic       ov_i,
    input  logic       lt_i,
    input  logic       eq_i,
    output logic       valid_o,
    input  logic       ready_i,
    output word_t      wdata_o,
    output reg_addr_t  wd_o,
    output logic       wreg_o,
    output word_t      hi_o,
    output word_t      lo_o,
    output logic       whilo_o,
    output logic       ov_o,
    output logic       trap_o
);

    logic   valid_q;
    logic   load;
    word_t  hi_q;
    word_t  lo_q;
    dword_t hilo_d;
    word_t  wdata_d;
    logic   trap_hit;
    logic   mov_ok;

    assign ready_o = !valid_q || ready_i;
    assign load    = valid_i && ready_o;
    assign valid_o = valid_q;
    assign hi_o    = hi_q;
    assign lo_o    = lo_q;

    //////////////////////////////
    // Write-back select
    always_comb begin
        case (sel_i)
            SEL_LOGIC: wdata_d = logic_i;
            SEL_SHIFT: wdata_d = shift_i;
            SEL_ARITH: wdata_d = arith_i;
            SEL_COUNT: wdata_d = word_t'(count_i);
            SEL_MUL:   wdata_d = prod_i[`WORD_W-1:0];
            SEL_MOVE:  wdata_d = src1_i;
            SEL_HILO:  wdata_d = (op_i == OP_MFHI) ? hi_q : lo_q;
            default:   wdata_d = '0;
        endcase
    end

    always_comb begin
        case (trap_i)
            TRAP_EQ: trap_hit = eq_i;
            TRAP_NE: trap_hit = !eq_i;
            TRAP_GE: trap_hit = !lt_i;
            TRAP_LT: trap_hit = lt_i;
            default: trap_hit = 1'b0;
        endcase
    end

    // MOVZ / MOVN condition on src2
    assign mov_ok = (op_i == OP_MOVZ) ? (src2_i == '0) :
                    (op_i == OP_MOVN) ? (src2_i != '0) : 1'b1;

    always_comb begin
        case (hilo_wr_i)
            HILO_PRODUCT: hilo_d = prod_i;
            HILO_HI:      hilo_d = {src1_i, lo_q};
            HILO_LO:      hilo_d = {hi_q, src1_i};
            default:      hilo_d = {hi_q, lo_q};
        endcase
    end

    //////////////////////////////
    // Output register and HI/LO
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            hi_q    <= '0;
            lo_q    <= '0;
        end else begin
            if (ready_o) begin
                valid_q <= valid_i;
            end
            if (load) begin
                {hi_q, lo_q} <= hilo_d;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            wdata_o <= wdata_d;
            wd_o    <= wd_i;
            wreg_o  <= wreg_i && !ov_i && mov_ok && (trap_i == TRAP_NONE);
            whilo_o <= (hilo_wr_i != HILO_NONE);
            ov_o    <= ov_i;
            trap_o  <= trap_hit;
        end
    end

    // Overflow and trap come from disjoint op groups
    a_ov_trap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_q |-> !(ov_o && trap_o));

endmodule

/* exe_stage.sv */
`timescale 1ns/100ps

module exe_stage import exe_ops_pkg::*, exe_data_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      valid_i,
    output logic      ready_o,
    input  exe_op_t   op_i,
    input  word_t     src1_i,
    input  word_t     src2_i,
    input  reg_addr_t wd_i,
    input  logic      wreg_i,
    output logic      valid_o,
    input  logic      ready_i,
    output word_t     wdata_o,
    output reg_addr_t wd_o,
    output logic      wreg_o,
    output word_t     hi_o,
    output word_t     lo_o,
    output logic      whilo_o,
    output logic      ov_o,
    output logic      trap_o
);

    // Decode to execute
    logic       d_valid, alu_ready;
    word_t      d_src1, d_src2;
    reg_addr_t  d_wd;
    logic       d_wreg, d_sub, d_signed, d_chk_ov;
    exe_op_t    d_op;
    res_sel_t   d_sel;
    trap_kind_t d_trap;
    hilo_wr_t   d_hilo_wr;

    // Execute to result
    logic       a_valid, res_ready;
    word_t      a_src1, a_src2;
    reg_addr_t  a_wd;
    logic       a_wreg;
    exe_op_t    a_op;
    res_sel_t   a_sel;
    trap_kind_t a_trap;
    hilo_wr_t   a_hilo_wr;
    word_t      a_logic, a_shift, a_arith;
    cnt_t       a_count;
    dword_t     a_prod;
    logic       a_ov, a_lt, a_eq;

    exe_decode i_exe_decode (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .valid_i   (valid_i),
        .ready_o   (ready_o),
        .op_i      (op_i),
        .src1_i    (src1_i),
        .src2_i    (src2_i),
        .wd_i      (wd_i),
        .wreg_i    (wreg_i),
        .valid_o   (d_valid),
        .ready_i   (alu_ready),
        .src1_o    (d_src1),
        .src2_o    (d_src2),
        .wd_o      (d_wd),
        .wreg_o    (d_wreg),
        .op_o      (d_op),
        .sel_o     (d_sel),
        .sub_o     (d_sub),
        .signed_o  (d_signed),
        .chk_ov_o  (d_chk_ov),
        .trap_o    (d_trap),
        .hilo_wr_o (d_hilo_wr)
    );

    exe_alu i_exe_alu (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .valid_i   (d_valid),
        .ready_o   (alu_ready),
        .src1_i    (d_src1),
        .src2_i    (d_src2),
        .wd_i      (d_wd),
        .wreg_i    (d_wreg),
        .op_i      (d_op),
        .sel_i     (d_sel),
        .sub_i     (d_sub),
        .signed_i  (d_signed),
        .chk_ov_i  (d_chk_ov),
        .trap_i    (d_trap),
        .hilo_wr_i (d_hilo_wr),
        .valid_o   (a_valid),
        .ready_i   (res_ready),
        .src1_o    (a_src1),
        .src2_o    (a_src2),
        .wd_o      (a_wd),
        .wreg_o    (a_wreg),
        .op_o      (a_op),
        .sel_o     (a_sel),
        .trap_o    (a_trap),
        .hilo_wr_o (a_hilo_wr),
        .logic_o   (a_logic),
        .shift_o   (a_shift),
        .arith_o   (a_arith),
        .count_o   (a_count),
        .prod_o    (a_prod),
        .ov_o      (a_ov),
        .lt_o      (a_lt),
        .eq_o      (a_eq)
    );

    exe_result i_exe_result (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .valid_i   (a_valid),
        .ready_o   (res_ready),
        .src1_i    (a_src1),
        .src2_i    (a_src2),
        .wd_i      (a_wd),
        .wreg_i    (a_wreg),
        .op_i      (a_op),
        .sel_i     (a_sel),
        .trap_i    (a_trap),
        .hilo_wr_i (a_hilo_wr),
        .logic_i   (a_logic),
        .shift_i   (a_shift),
        .arith_i   (a_arith),
        .count_i   (a_count),
        .prod_i    (a_prod),
        .ov_i      (a_ov),
        .lt_i      (a_lt),
        .eq_i      (a_eq),
        .valid_o   (valid_o),
        .ready_i   (ready_i),
        .wdata_o   (wdata_o),
        .wd_o      (wd_o),
        .wreg_o    (wreg_o),
        .hi_o      (hi_o),
        .lo_o      (lo_o),
        .whilo_o   (whilo_o),
        .ov_o      (ov_o),
        .trap_o    (trap_o)
    );

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // Synchronous reset held for 16 rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

/* tb_exe_stage.sv */
`timescale 1ns/100ps

module tb_exe_stage import exe_ops_pkg::*, exe_data_pkg::*; ();

    // About 220 operations, up to ~4 cycles each under back-pressure, plus reset and drains
    localparam int CYCLE_LIMIT = 3000;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic       in_ready;
    exe_op_t    in_op;
    word_t      in_src1;
    word_t      in_src2;
    reg_addr_t  in_wd;
    logic       in_wreg;
    logic       out_valid;
    logic       out_ready = 1'b1;
    word_t      out_wdata;
    reg_addr_t  out_wd;
    logic       out_wreg;
    word_t      out_hi;
    word_t      out_lo;
    logic       out_whilo;
    logic       out_ov;
    logic       out_trap;

    logic [31:0] lfsr_q = 32'd64;
    logic        bp_en = 1'b0;
    int          cycle = 0;
    int          errors = 0;
    int          n_out = 0;
    int          n_tests = 0;

    // Reference HI/LO
    word_t       m_hi = '0;
    word_t       m_lo = '0;

    // Accepted operations, oldest first
    exe_op_t     q_op[$];
    word_t       q_a[$];
    word_t       q_b[$];
    reg_addr_t   q_wd[$];
    logic        q_wreg[$];

    tb_clk_gen i_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    exe_stage i_exe_stage (
        .clk_i   (clk),
        .rst_n_i (rst_n),
        .valid_i (in_valid),
        .ready_o (in_ready),
        .op_i    (in_op),
        .src1_i  (in_src1),
        .src2_i  (in_src2),
        .wd_i    (in_wd),
        .wreg_i  (in_wreg),
        .valid_o (out_valid),
        .ready_i (out_ready),
        .wdata_o (out_wdata),
        .wd_o    (out_wd),
        .wreg_o  (out_wreg),
        .hi_o    (out_hi),
        .lo_o    (out_lo),
        .whilo_o (out_whilo),
        .ov_o    (out_ov),
        .trap_o  (out_trap)
    );

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    //////////////////////////////
    // Reference model
    task automatic model_op(input exe_op_t op, input word_t a, input word_t b, input logic wreg,
                            output word_t wdata, output logic wreg_e, output logic has_word,
                            output logic whilo, output logic ov, output logic trap);
        longint      s;
        logic [63:0] p;
        logic        mov_ok;
        logic        is_trap;
        int          n;
        wdata = '0;
        has_word = 1'b1;
        whilo = 1'b0;
        ov = 1'b0;
        trap = 1'b0;
        mov_ok = 1'b1;
        is_trap = 1'b0;
        case (op)
            OP_OR:  wdata = a | b;
            OP_AND: wdata = a & b;
            OP_NOR: wdata = ~(a | b);
            OP_XOR: wdata = a ^ b;
            OP_SLL: wdata = b << a[4:0];
            OP_SRL: wdata = b >> a[4:0];
            OP_SRA: wdata = (b >> a[4:0]) | (b[31] ? ~(32'hffff_ffff >> a[4:0]) : 32'h0);
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: begin
                if (op == OP_ADD || op == OP_ADDU) begin
                    s = longint'($signed(a)) + longint'($signed(b));
                end else begin
                    s = longint'($signed(a)) - longint'($signed(b));
                end
                wdata = word_t'(s);
                // Overflow when the sum does not fit in 32 signed bits
                ov = (op == OP_ADD || op == OP_SUB) && (s != longint'($signed(word_t'(s))));
            end
            OP_SLT:  wdata = word_t'($signed(a) < $signed(b));
            OP_SLTU: wdata = word_t'(a < b);
            OP_CLZ, OP_CLO: begin
                n = 0;
                while (n < 32 && a[31 - n] == (op == OP_CLO)) begin
                    n++;
                end
                wdata = word_t'(n);
            end
            OP_MUL: begin
                p = 64'(longint'($signed(a)) * longint'($signed(b)));
                wdata = p[31:0];
            end
            OP_MULT, OP_MULTU: begin
                if (op == OP_MULT) begin
                    p = 64'(longint'($signed(a)) * longint'($signed(b)));
                end else begin
                    p = {32'h0, a} * {32'h0, b};
                end
                m_hi = p[63:32];
                m_lo = p[31:0];
                whilo = 1'b1;
                has_word = 1'b0;
            end
            OP_MFHI: wdata = m_hi;
            OP_MFLO: wdata = m_lo;
            OP_MTHI, OP_MTLO: begin
                if (op == OP_MTHI) begin
                    m_hi = a;
                end else begin
                    m_lo = a;
                end
                whilo = 1'b1;
                has_word = 1'b0;
            end
            OP_MOVZ, OP_MOVN: begin
                wdata = a;
                mov_ok = (op == OP_MOVZ) ? (b == '0) : (b != '0);
            end
            default: begin
                is_trap = 1'b1;
                has_word = 1'b0;
                case (op)
                    OP_TEQ:  trap = (a == b);
                    OP_TNE:  trap = (a != b);
                    OP_TGE:  trap = ($signed(a) >= $signed(b));
                    OP_TGEU: trap = (a >= b);
                    OP_TLT:  trap = ($signed(a) < $signed(b));
                    default: trap = (a < b);
                endcase
            end
        endcase
        wreg_e = wreg && !ov && mov_ok && !is_trap;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic check_item();
        exe_op_t   op;
        word_t     a, b, exp_wdata;
        reg_addr_t wd;
        logic      wreg, exp_wreg, has_word, exp_whilo, exp_ov, exp_trap;
        op = q_op.pop_front();
        a = q_a.pop_front();
        b = q_b.pop_front();
        wd = q_wd.pop_front();
        wreg = q_wreg.pop_front();
        model_op(op, a, b, wreg, exp_wdata, exp_wreg, has_word, exp_whilo, exp_ov, exp_trap);
        if (has_word && out_wdata !== exp_wdata) report_mismatch("wdata_o", out_wdata, exp_wdata);
        if (out_wd !== wd) report_mismatch("wd_o", 32'(out_wd), 32'(wd));
        if (out_wreg !== exp_wreg) report_mismatch("wreg_o", 32'(out_wreg), 32'(exp_wreg));
        if (out_whilo !== exp_whilo) report_mismatch("whilo_o", 32'(out_whilo), 32'(exp_whilo));
        if (exp_whilo && out_hi !== m_hi) report_mismatch("hi_o", out_hi, m_hi);
        if (exp_whilo && out_lo !== m_lo) report_mismatch("lo_o", out_lo, m_lo);
        if (out_ov !== exp_ov) report_mismatch("ov_o", 32'(out_ov), 32'(exp_ov));
        if (out_trap !== exp_trap) report_mismatch("trap_o", 32'(out_trap), 32'(exp_trap));
    endtask

    //////////////////////////////
    // Output monitor and ready toggling
    always @(negedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            n_out++;
            if (q_op.size() == 0) begin
                $display("ERROR t=%0t output item with no operation pending", $time);
                errors++;
            end else begin
                check_item();
            end
        end
    end

    always @(posedge clk) begin
        if (bp_en) begin
            out_ready <= 1'(rand_bits(1));
        end else begin
            out_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    //////////////////////////////
    // Driver
    task automatic send_op(input exe_op_t op, input word_t a, input word_t b,
                           input reg_addr_t wd, input logic wreg);
        @(posedge clk);
        in_valid <= 1'b1;
        in_op <= op;
        in_src1 <= a;
        in_src2 <= b;
        in_wd <= wd;
        in_wreg <= wreg;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        // Taken on the coming edge
        q_op.push_back(op);
        q_a.push_back(a);
        q_b.push_back(b);
        q_wd.push_back(wd);
        q_wreg.push_back(wreg);
    endtask

    task automatic send_rand(input exe_op_t op);
        word_t     a;
        word_t     b;
        reg_addr_t wd;
        logic      wreg;
        a = rand_bits(32);
        b = rand_bits(32);
        wd = reg_addr_t'(rand_bits(5));
        wreg = 1'(rand_bits(1));
        send_op(op, a, b, wd, wreg);
    endtask

    task automatic wait_drain();
        @(posedge clk);
        in_valid <= 1'b0;
        while (q_op.size() != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    task automatic finish_test(input string name, input int err0);
        n_tests++;
        $display("%-12s done, %0d errors", name, errors - err0);
    endtask

    //////////////////////////////
    // Directed tests
    task automatic test_logic_shift();
        int err0;
        err0 = errors;
        for (int i = 0; i < 21; i++) begin
            send_rand(exe_op_t'(i % 7));
        end
        send_op(OP_SRA, 32'd7, 32'h8765_4321, 5'd1, 1'b1);
        send_op(OP_SRA, 32'd31, 32'hf000_0000, 5'd2, 1'b1);
        send_op(OP_SRA, rand_bits(32), rand_bits(32) | 32'h8000_0000, 5'd3, 1'b1);
        wait_drain();
        finish_test("logic_shift", err0);
    endtask

    task automatic test_arith();
        int err0;
        err0 = errors;
        for (int i = 0; i < 24; i++) begin
            send_rand(exe_op_t'(int'(OP_ADD) + i % 6));
        end
        // Forced signed overflow
        send_op(OP_ADD, 32'h7fff_ffff, 32'h1, 5'd4, 1'b1);
        send_op(OP_ADD, 32'h8000_0000, 32'h8000_0000, 5'd5, 1'b1);
        send_op(OP_SUB, 32'h8000_0000, 32'h1, 5'd6, 1'b1);
        send_op(OP_SUB, 32'h7fff_ffff, 32'hffff_ffff, 5'd7, 1'b1);
        send_op(OP_ADDU, 32'h7fff_ffff, 32'h1, 5'd8, 1'b1);
        send_op(OP_SLT, 32'hffff_ffff, 32'h1, 5'd9, 1'b1);
        send_op(OP_SLTU, 32'hffff_ffff, 32'h1, 5'd10, 1'b1);
        wait_drain();
        finish_test("arith", err0);
    endtask

    task automatic test_count();
        int    err0;
        word_t a;
        err0 = errors;
        send_op(OP_CLZ, 32'h0, 32'h0, 5'd1, 1'b1);
        send_op(OP_CLZ, 32'hffff_ffff, 32'h0, 5'd2, 1'b1);
        send_op(OP_CLO, 32'hffff_ffff, 32'h0, 5'd3, 1'b1);
        send_op(OP_CLO, 32'h0, 32'h0, 5'd4, 1'b1);
        for (int i = 0; i < 8; i++) begin
            a = rand_bits(32) >> rand_bits(5);
            send_op(OP_CLZ, a, 32'h0, 5'(i), 1'b1);
            send_op(OP_CLO, ~a, 32'h0, 5'(i), 1'b1);
        end
        wait_drain();
        finish_test("count", err0);
    endtask

    task automatic test_hilo();
        int err0;
        err0 = errors;
        send_rand(OP_MULT);
        send_op(OP_MFHI, 32'h0, 32'h0, 5'd1, 1'b1);
        send_op(OP_MFLO, 32'h0, 32'h0, 5'd2, 1'b1);
        send_op(OP_MULTU, 32'hffff_ffff, 32'hffff_ffff, 5'd0, 1'b0);
        send_op(OP_MFHI, 32'h0, 32'h0, 5'd3, 1'b1);
        send_op(OP_MFLO, 32'h0, 32'h0, 5'd4, 1'b1);
        send_op(OP_MULT, 32'hffff_fffd, 32'd5, 5'd0, 1'b0);
        send_op(OP_MFHI, 32'h0, 32'h0, 5'd5, 1'b1);
        send_op(OP_MTHI, rand_bits(32), 32'h0, 5'd0, 1'b0);
        send_op(OP_MFHI, 32'h0, 32'h0, 5'd6, 1'b1);
        send_op(OP_MTLO, rand_bits(32), 32'h0, 5'd0, 1'b0);
        send_op(OP_MFLO, 32'h0, 32'h0, 5'd7, 1'b1);
        send_rand(OP_MUL);
        send_op(OP_MUL, 32'hffff_fff9, 32'd9, 5'd8, 1'b1);
        wait_drain();
        finish_test("hilo", err0);
    endtask

    task automatic test_move_trap();
        int    err0;
        word_t a;
        err0 = errors;
        a = rand_bits(32);
        send_op(OP_MOVZ, a, 32'h0, 5'd1, 1'b1);
        send_op(OP_MOVZ, a, 32'h10, 5'd2, 1'b1);
        send_op(OP_MOVN, a, 32'h0, 5'd3, 1'b1);
        send_op(OP_MOVN, a, 32'h10, 5'd4, 1'b1);
        for (int k = 0; k < 6; k++) begin
            send_op(exe_op_t'(int'(OP_TEQ) + k), a, a, 5'd5, 1'b1);
            send_op(exe_op_t'(int'(OP_TEQ) + k), 32'hffff_ffff, 32'h1, 5'd6, 1'b1);
            send_op(exe_op_t'(int'(OP_TEQ) + k), 32'h1, 32'hffff_ffff, 5'd7, 1'b1);
            send_rand(exe_op_t'(int'(OP_TEQ) + k));
        end
        wait_drain();
        finish_test("move_trap", err0);
    endtask

    task automatic test_latency();
        int err0;
        int acc;
        err0 = errors;
        send_op(OP_ADDU, 32'd5, 32'd6, 5'd3, 1'b1);
        acc = cycle + 1;
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        while (!out_valid) begin
            @(negedge clk);
        end
        if (cycle != acc + 2) begin
            $display("ERROR t=%0t valid_o cycle got %0d expected %0d", $time, cycle, acc + 2);
            errors++;
        end
        wait_drain();
        finish_test("latency", err0);
    endtask

    task automatic test_stream();
        int      err0;
        int      out0;
        exe_op_t op;
        word_t   a;
        word_t   b;
        err0 = errors;
        out0 = n_out;
        bp_en = 1'b1;
        for (int i = 0; i < 100; i++) begin
            op = exe_op_t'(5'(rand_bits(5) % 30));
            a = rand_bits(32);
            b = rand_bits(32);
            // Zero and equal operands now and then for moves and traps
            if (rand_bits(2) == 0) begin
                b = '0;
            end else if (rand_bits(2) == 1) begin
                b = a;
            end
            send_op(op, a, b, reg_addr_t'(rand_bits(5)), 1'(rand_bits(1)));
        end
        wait_drain();
        bp_en = 1'b0;
        // Room for any repeated item to come out
        repeat (4) @(negedge clk);
        if (n_out - out0 != 100) begin
            $display("Stream returned %0d items for 100 operations", n_out - out0);
            errors++;
        end
        finish_test("stream", err0);
    endtask

    initial begin
        in_valid = 1'b0;
        in_op = OP_OR;
        in_src1 = '0;
        in_src2 = '0;
        in_wd = '0;
        in_wreg = 1'b0;
        wait (rst_n);
        @(negedge clk);
        test_logic_shift();
        test_arith();
        test_count();
        test_hilo();
        test_move_trap();
        test_latency();
        test_stream();
        $display("Summary: %0d tests, %0d outputs, %0d errors", n_tests, n_out, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
exe_ops_pkg.sv
exe_data_pkg.sv
exe_decode.sv
exe_alu.sv
exe_result.sv
exe_stage.sv
tb_clk_gen.sv
tb_exe_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass message in the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module tb_exe_stage \
    -Mdir obj_dir -o tb_exe_stage > build.log 2>&1 &&
./obj_dir/tb_exe_stage > sim.log 2>&1
cat sim.log 2>/dev/null || cat build.log
grep -q "Test completed successfully" sim.log 2>/dev/null && echo "Simulation passed" ||
{ echo "Simulation did not pass"; exit 1; }
